// File: all.f
hdl/geomPkg.sv
hdl/colorPkg.sv
hdl/livesTracker.sv
hdl/layerSelect.sv
hdl/paletteMap.sv
hdl/colorMapper.sv
dv/colorMapperTb.sv

// File: Bender.yml
package:
  name: color_mapper

sources:
  - hdl/geomPkg.sv
  - hdl/colorPkg.sv
  - hdl/livesTracker.sv
  - hdl/layerSelect.sv
  - hdl/paletteMap.sv
  - hdl/colorMapper.sv
  - target: simulation
    files:
      - dv/colorMapperTb.sv

// File: dv/colorMapperTb.sv
/* Testbench for the pixel colour stage.
   Table-driven pixel and lives checks, then a random background sweep. */

`timescale 1ns/100ps

module colorMapperTb;

    import geomPkg::*;
    import colorPkg::*;

    localparam int ResetCycles = 16;
    localparam int RandomCount = 200;
    localparam int SpareCycles = 20;

    typedef struct {
        coordT       ballX;
        coordT       ballY;
        coordT       ballSize;
        coordT       drawX;
        coordT       drawY;
        logic        blank;
        logic [23:0] rgb;
        livesT       lives;
    } entryT;

    logic    Clk;
    logic    Reset;
    coordT   drawX;
    coordT   drawY;
    logic    blank;
    coordT   ballX;
    coordT   ballY;
    coordT   ballSize;
    channelT red;
    channelT green;
    channelT blue;
    livesT   lives;

    entryT       stimTable[$];
    logic [23:0] rgbQ[$];
    livesT       livesQ[$];
    int          cycleCount = 0;
    int          cycleLimit = 0;

    colorMapper dut_i (
        .Clk      (Clk),
        .Reset    (Reset),
        .DrawX    (drawX),
        .DrawY    (drawY),
        .Blank    (blank),
        .BallX    (ballX),
        .BallY    (ballY),
        .BallSize (ballSize),
        .Red      (red),
        .Green    (green),
        .Blue     (blue),
        .Lives    (lives)
    );

    initial
    begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    // run limit from reset, table and random sweep lengths
    always @(posedge Clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit)
            reportFailure($sformatf("Timeout: run did not finish within %0d cycles",
                cycleLimit));
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic checkColour(input channelT expRed, input channelT expGreen,
                               input channelT expBlue);
        if (red !== expRed || green !== expGreen || blue !== expBlue)
            reportFailure($sformatf(
                "Mismatch at %0t ns: {Red,Green,Blue} = %h %h %h, expected %h %h %h",
                $time, red, green, blue, expRed, expGreen, expBlue));
    endtask

    task automatic checkLives(input livesT expLives);
        if (lives !== expLives)
            reportFailure($sformatf("Mismatch at %0t ns: Lives = %0d, expected %0d",
                $time, lives, expLives));
    endtask

    // lives lag the pixel by one cycle and colour by two
    task automatic checkPending(input int rgbDepth);
        logic [23:0] rgb;
        if (livesQ.size() > 0)
            checkLives(livesQ.pop_front());
        if (rgbQ.size() >= rgbDepth)
        begin
            rgb = rgbQ.pop_front();
            checkColour(rgb[23:16], rgb[15:8], rgb[7:0]);
        end
    endtask

    task automatic applyEntry(input entryT e);
        @(posedge Clk);
        #2;
        checkPending(2);
        ballX = e.ballX;
        ballY = e.ballY;
        ballSize = e.ballSize;
        drawX = e.drawX;
        drawY = e.drawY;
        blank = e.blank;
        rgbQ.push_back(e.rgb);
        livesQ.push_back(e.lives);
    endtask

    // ----------------------------------------------------------------------
    // stimulus table
    // ----------------------------------------------------------------------

    task automatic addEntry(input coordT bx, input coordT by, input coordT bs,
                            input coordT dx, input coordT dy, input logic bl,
                            input logic [23:0] rgb, input livesT lv);
        entryT e;
        e = '{bx, by, bs, dx, dy, bl, rgb, lv};
        stimTable.push_back(e);
    endtask

    // hearts use the lives count from before the entry
    task automatic buildTable();
        // blanking beats everything including the ball
        addEntry(10, 10, 20, 15, 15, 1'b0, BlankRgb, 2'd3);
        addEntry(10, 10, 20, 320, 400, 1'b0, BlankRgb, 2'd3);
        addEntry(10, 10, 20, 460, 30, 1'b0, BlankRgb, 2'd3);
        // all three hearts and their box edges
        addEntry(10, 10, 20, 450, 20, 1'b1, HeartRgb, 2'd3);
        addEntry(10, 10, 20, 525, 44, 1'b1, HeartRgb, 2'd3);
        addEntry(10, 10, 20, 599, 69, 1'b1, HeartRgb, 2'd3);
        addEntry(10, 10, 20, 600, 40, 1'b1, BackgroundRgb, 2'd3);
        addEntry(10, 10, 20, 470, 70, 1'b1, BackgroundRgb, 2'd3);
        addEntry(10, 10, 20, 15, 15, 1'b1, BallRgb, 2'd3);
        addEntry(10, 10, 20, 30, 15, 1'b1, BackgroundRgb, 2'd3);
        // ball overlaps pipe but its corner stays outside
        addEntry(280, 370, 40, 310, 390, 1'b1, BallRgb, 2'd3);
        addEntry(280, 370, 40, 300, 380, 1'b1, BallRgb, 2'd3);
        addEntry(280, 370, 40, 330, 390, 1'b1, PipeRgb, 2'd3);
        addEntry(280, 370, 40, 349, 479, 1'b1, PipeRgb, 2'd3);
        addEntry(280, 370, 40, 350, 400, 1'b1, BackgroundRgb, 2'd3);
        addEntry(280, 370, 40, 320, 400, 1'b1, PipeRgb, 2'd3);
        addEntry(280, 370, 40, 290, 375, 1'b1, BallRgb, 2'd3);
        addEntry(280, 370, 40, 299, 420, 1'b1, BackgroundRgb, 2'd3);
        // first collision takes the left heart
        addEntry(310, 400, 20, 5, 5, 1'b1, BackgroundRgb, 2'd2);
        addEntry(320, 420, 20, 460, 30, 1'b1, BackgroundRgb, 2'd2);
        addEntry(340, 420, 20, 510, 30, 1'b1, HeartRgb, 2'd2);
        addEntry(351, 420, 20, 345, 430, 1'b1, PipeRgb, 2'd2);
        addEntry(400, 420, 20, 560, 60, 1'b1, HeartRgb, 2'd2);
        // second collision
        addEntry(305, 385, 20, 305, 385, 1'b1, BallRgb, 2'd1);
        addEntry(305, 385, 20, 510, 30, 1'b1, BackgroundRgb, 2'd1);
        addEntry(305, 385, 20, 560, 30, 1'b1, HeartRgb, 2'd1);
        // third collision and game over holding
        addEntry(360, 400, 20, 459, 40, 1'b1, BackgroundRgb, 2'd1);
        addEntry(301, 381, 20, 100, 100, 1'b1, BackgroundRgb, 2'd0);
        addEntry(301, 381, 20, 560, 30, 1'b1, BackgroundRgb, 2'd0);
        addEntry(400, 400, 20, 460, 30, 1'b1, BackgroundRgb, 2'd0);
        addEntry(320, 400, 20, 510, 30, 1'b1, BackgroundRgb, 2'd0);
        addEntry(320, 400, 20, 325, 405, 1'b1, BallRgb, 2'd0);
        addEntry(320, 400, 20, 325, 405, 1'b0, BlankRgb, 2'd0);
        addEntry(10, 10, 20, 560, 30, 1'b1, BackgroundRgb, 2'd0);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial
    begin : mainSeq
        entryT e;
        void'($urandom(12245));
        Reset = 1'b1;
        drawX = '0;
        drawY = '0;
        blank = 1'b0;
        ballX = 10'd10;
        ballY = 10'd10;
        ballSize = 10'd20;
        buildTable();
        cycleLimit = ResetCycles + stimTable.size() + RandomCount + SpareCycles;
        repeat (ResetCycles) @(posedge Clk);
        #2;
        Reset = 1'b0;

        foreach (stimTable[i])
            applyEntry(stimTable[i]);

        // ball parked top left with pixels between heart row and pipe
        repeat (RandomCount)
        begin
            e.ballX = 10'd10;
            e.ballY = 10'd10;
            e.ballSize = 10'd20;
            e.drawX = coordT'($urandom_range(639, 0));
            e.drawY = coordT'($urandom_range(379, 70));
            e.blank = 1'b1;
            e.rgb = BackgroundRgb;
            e.lives = 2'd0;
            applyEntry(e);
        end

        repeat (2)
        begin
            @(posedge Clk);
            #2;
            checkPending(1);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: hdl/colorMapper.sv
/* Pixel colour stage of the side-scroller.
   Lives tracking, layer selection and palette lookup, two cycles deep. */

`timescale 1ns/100ps

module colorMapper (
    input  logic              Clk,
    input  logic              Reset,
    input  geomPkg::coordT    DrawX,
    input  geomPkg::coordT    DrawY,
    input  logic              Blank,
    input  geomPkg::coordT    BallX,
    input  geomPkg::coordT    BallY,
    input  geomPkg::coordT    BallSize,
    output colorPkg::channelT Red,
    output colorPkg::channelT Green,
    output colorPkg::channelT Blue,
    output geomPkg::livesT    Lives
);

    import colorPkg::*;

    // first pipeline stage output
    layerT layer;

    livesTracker tracker (
        .Clk   (Clk),
        .Reset (Reset),
        .BallX (BallX),
        .BallY (BallY),
        .Lives (Lives)
    );

    layerSelect selector (
        .Clk      (Clk),
        .Reset    (Reset),
        .DrawX    (DrawX),
        .DrawY    (DrawY),
        .BallX    (BallX),
        .BallY    (BallY),
        .BallSize (BallSize),
        .Blank    (Blank),
        .Lives    (Lives),
        .Layer    (layer)
    );

    paletteMap palette (
        .Clk   (Clk),
        .Reset (Reset),
        .Layer (layer),
        .Red   (Red),
        .Green (Green),
        .Blue  (Blue)
    );

endmodule

// File: hdl/paletteMap.sv
/* Palette stage, maps the selected layer to a registered RGB pixel. */

`timescale 1ns/100ps

module paletteMap (
    input  logic              Clk,
    input  logic              Reset,
    input  colorPkg::layerT   Layer,
    output colorPkg::channelT Red,
    output colorPkg::channelT Green,
    output colorPkg::channelT Blue
);

    import colorPkg::*;

    logic [23:0] rgbNext;

    always_comb
    begin
        case (Layer)
            LayerBall:       rgbNext = BallRgb;
            LayerPipe:       rgbNext = PipeRgb;
            LayerHeart:      rgbNext = HeartRgb;
            LayerBackground: rgbNext = BackgroundRgb;
            // blanking and unused codes
            default:         rgbNext = BlankRgb;
        endcase
    end

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            Red <= '0;
            Green <= '0;
            Blue <= '0;
        end
        else
        begin
            Red <= rgbNext[23:16];
            Green <= rgbNext[15:8];
            Blue <= rgbNext[7:0];
        end
    end

    blankLayerIsBlack: assert property (@(posedge Clk) disable iff (Reset)
        Layer == LayerBlank |=> {Red, Green, Blue} == 24'h0);

endmodule

// File: hdl/layerSelect.sv
/* Per-pixel layer selection.
   Hit-tests ball, pipe and hearts and registers the layer on top. */

`timescale 1ns/100ps

module layerSelect (
    input  logic            Clk,
    input  logic            Reset,
    input  geomPkg::coordT  DrawX,
    input  geomPkg::coordT  DrawY,
    input  geomPkg::coordT  BallX,
    input  geomPkg::coordT  BallY,
    input  geomPkg::coordT  BallSize,
    input  logic            Blank,
    input  geomPkg::livesT  Lives,
    output colorPkg::layerT Layer
);

    import geomPkg::*;
    import colorPkg::*;

    // half-open box test, edges summed at 11 bits so a ball near
    // the right border cannot wrap around
    function automatic logic inBox(
        input coordT px,
        input coordT py,
        input coordT bx,
        input coordT by,
        input coordT w,
        input coordT h
    );
        logic [10:0] rightEdge;
        logic [10:0] bottomEdge;
        rightEdge = {1'b0, bx} + {1'b0, w};
        bottomEdge = {1'b0, by} + {1'b0, h};
        return (px >= bx) && ({1'b0, px} < rightEdge) &&
               (py >= by) && ({1'b0, py} < bottomEdge);
    endfunction

    logic       ballHit;
    logic       pipeHit;
    logic [2:0] heartHit;
    layerT      layerNext;

    assign ballHit = inBox(DrawX, DrawY, BallX, BallY, BallSize, BallSize);
    assign pipeHit = inBox(DrawX, DrawY, PipeX, PipeY, PipeW, PipeH);

    // left heart goes first, so heart k needs more than 2 - k lives
    assign heartHit[0] = inBox(DrawX, DrawY, HeartX0, HeartY, HeartSize, HeartSize) &&
                         (Lives > 2'd2);
    assign heartHit[1] = inBox(DrawX, DrawY, HeartX1, HeartY, HeartSize, HeartSize) &&
                         (Lives > 2'd1);
    assign heartHit[2] = inBox(DrawX, DrawY, HeartX2, HeartY, HeartSize, HeartSize) &&
                         (Lives > 2'd0);

    // priority: blank, ball, pipe, heart, background
    always_comb
    begin
        if (!Blank)
            layerNext = LayerBlank;
        else if (ballHit)
            layerNext = LayerBall;
        else if (pipeHit)
            layerNext = LayerPipe;
        else if (|heartHit)
            layerNext = LayerHeart;
        else
            layerNext = LayerBackground;
    end

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            Layer <= LayerBlank;
        else
            Layer <= layerNext;
    end

    // blanking wins over every sprite
    blankGivesBlankLayer: assert property (@(posedge Clk) disable iff (Reset)
        !Blank |=> Layer == LayerBlank);

endmodule

// File: hdl/livesTracker.sv
/* Life counter for the side-scroller.
   Takes one life per ball collision with the pipe, stops at game over. */

`timescale 1ns/100ps

module livesTracker (
    input  logic          Clk,
    input  logic          Reset,
    input  geomPkg::coordT BallX,
    input  geomPkg::coordT BallY,
    output geomPkg::livesT Lives
);

    import geomPkg::*;

    typedef enum logic [2:0] {
        LivesThree,
        CrashOne,
        LivesTwo,
        CrashTwo,
        LivesOne,
        GameOver
    } stateT;

    stateT state;
    stateT stateNext;
    logic  collision;
    logic  cleared;

    // top-left corner of the ball strictly inside the pipe box
    assign collision = (BallX > PipeX) && (BallX < PipeX + PipeW) &&
                       (BallY > PipeY) && (BallY < PipeY + PipeH);

    // ball has passed the pipe's right edge
    assign cleared = BallX > PipeX + PipeW;

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            state <= LivesThree;
        else
            state <= stateNext;
    end

    always_comb
    begin
        stateNext = state;
        case (state)
            LivesThree: if (collision) stateNext = CrashOne;
            CrashOne:   if (cleared) stateNext = LivesTwo;
            LivesTwo:   if (collision) stateNext = CrashTwo;
            CrashTwo:   if (cleared) stateNext = LivesOne;
            LivesOne:   if (collision) stateNext = GameOver;
            // held until reset
            GameOver:   stateNext = GameOver;
            default:    stateNext = LivesThree;
        endcase
    end

    // life already gone while the ball is still in the pipe
    always_comb
    begin
        case (state)
            LivesThree:         Lives = LivesMax;
            CrashOne, LivesTwo: Lives = 2'd2;
            CrashTwo, LivesOne: Lives = 2'd1;
            default:            Lives = 2'd0;
        endcase
    end

    // lives only ever count down between resets
    livesNeverRise: assert property (@(posedge Clk) disable iff (Reset)
        Lives <= $past(Lives));

endmodule

// File: hdl/colorPkg.sv
/* Colour definitions for the pixel stage.
   Layer encoding, channel type and the fixed sprite palette. */

package colorPkg;

    // ----------------------------------------------------------------------
    // layer that covers a pixel
    // ----------------------------------------------------------------------

    typedef enum logic [2:0] {
        LayerBlank,
        LayerBall,
        LayerPipe,
        LayerHeart,
        LayerBackground
    } layerT;

    // ----------------------------------------------------------------------
    // colours
    // ----------------------------------------------------------------------

    // one 8-bit VGA DAC channel
    typedef logic [7:0] channelT;

    // palette as {red, green, blue}
    localparam logic [23:0] BallRgb = 24'h00FF44;
    localparam logic [23:0] PipeRgb = 24'hCC7711;
    localparam logic [23:0] HeartRgb = 24'hDD00FF;

    // sky blue behind all sprites
    localparam logic [23:0] BackgroundRgb = 24'h0000FF;

    // DAC must output black outside the visible area
    localparam logic [23:0] BlankRgb = 24'h000000;

endpackage

// File: hdl/geomPkg.sv
/* Screen geometry for the side-scroller colour stage.
   Pixel coordinate type, fixed sprite boxes and the life count type. */

package geomPkg;

    // ----------------------------------------------------------------------
    // screen coordinates
    // ----------------------------------------------------------------------

    // 640 x 480 raster, 10 bits covers both axes
    typedef logic [9:0] coordT;

    // ----------------------------------------------------------------------
    // pipe obstacle box
    // ----------------------------------------------------------------------

    localparam coordT PipeX = 10'd300;
    localparam coordT PipeY = 10'd380;
    localparam coordT PipeW = 10'd50;
    // reaches the bottom line of the screen
    localparam coordT PipeH = 10'd100;

    // ----------------------------------------------------------------------
    // life hearts, top right corner
    // ----------------------------------------------------------------------

    localparam coordT HeartX0 = 10'd450;
    localparam coordT HeartX1 = 10'd500;
    localparam coordT HeartX2 = 10'd550;
    localparam coordT HeartY = 10'd20;
    localparam coordT HeartSize = 10'd50;

    // ----------------------------------------------------------------------
    // lives
    // ----------------------------------------------------------------------

    typedef logic [1:0] livesT;

    localparam livesT LivesMax = 2'd3;

endpackage
